/* logic/glyph_pkg.sv */
// glyph painter shared types
package glyph_pkg;

	// screen geometry, 160x120 grid
	typedef logic [7:0] coord_x_t;
	typedef logic [6:0] coord_y_t;
	typedef logic [2:0] colour_t;	// one bit per rgb channel

	typedef enum logic [1:0] {
		UP    = 2'd0,
		DOWN  = 2'd1,
		LEFT  = 2'd2,
		RIGHT = 2'd3
	} direction_t;

	// one pixel write on the shared bus
	typedef struct packed {
		logic     valid;
		coord_x_t x;
		coord_y_t y;
		colour_t  colour;
	} pixel_write_t;

	localparam coord_x_t ORIGIN_X = 8'd79;	// every arrow starts here
	localparam coord_y_t ORIGIN_Y = 7'd63;

	localparam logic [3:0] STEM_LEN = 4'd8;
	localparam logic [3:0] WING_LEN = 4'd4;
	localparam logic [4:0] GLYPH_PIXELS = 5'd16;	// stem plus both wings

	localparam colour_t COLOUR_ERASE = 3'b000;

	// drawing colour of each direction
	function automatic colour_t dir_colour(input direction_t d);
		colour_t c;
		case (d)
			UP:      c = 3'b111;
			DOWN:    c = 3'b001;
			RIGHT:   c = 3'b011;
			default: c = 3'b010;	// LEFT
		endcase
		return c;
	endfunction

endpackage

/* logic/glyph_picker.sv */
// direction picker
module glyph_picker
	import glyph_pkg::*;
(
	input  logic       clk,
	input  logic       reset_n,
	input  logic       advance,
	output direction_t dir
);

	logic [3:0] lfsr;

	// shifts toward msb, feedback from the two top bits
	always_ff @(posedge clk)
	begin
		if (!reset_n)
			lfsr <= 4'b1110;
		else if (advance)
			lfsr <= {lfsr[2:0], lfsr[2] ^ lfsr[3]};
	end

	// threshold mapping, quarters of the lfsr range
	always_comb
	begin
		if (lfsr < 4'd4)
			dir = UP;
		else if (lfsr < 4'd8)
			dir = DOWN;
		else if (lfsr < 4'd12)
			dir = LEFT;
		else
			dir = RIGHT;
	end

	// all-zero state would lock the sequence up
	a_lfsr_nonzero: assert property (@(posedge clk) disable iff (!reset_n)
		lfsr != 4'd0);

endmodule

/* logic/glyph_tracer.sv */
// arrow pixel tracer
module glyph_tracer
	import glyph_pkg::*;
#(
	parameter int STEP_CYCLES = 4,
	parameter bit ERASE = 1'b0
) (
	input  logic         clk,
	input  logic         reset_n,
	input  logic         start,
	input  direction_t   dir,
	input  logic         grant,
	output pixel_write_t req,
	output logic         busy
);

	localparam int CNT_W = $clog2(STEP_CYCLES + 1);

	localparam logic [1:0] SEG_STEM = 2'd0;
	localparam logic [1:0] SEG_A    = 2'd1;
	localparam logic [1:0] SEG_B    = 2'd2;

	logic             active;
	logic             valid_q;
	logic [CNT_W-1:0] step_cnt;
	logic [1:0]       seg;
	logic [3:0]       pos;	// multiplier of the segment vector
	logic [4:0]       pix_cnt;
	direction_t       dir_q;
	logic             x_inc, x_dec, y_inc, y_dec;
	coord_x_t         off_x;
	coord_y_t         off_y;

	always_ff @(posedge clk)
	begin
		if (start)
			dir_q <= dir;
	end

	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			active   <= 1'b0;
			valid_q  <= 1'b0;
			step_cnt <= '0;
			seg      <= SEG_STEM;
			pos      <= 4'd0;
			pix_cnt  <= 5'd0;
		end
		else if (start)
		begin
			active   <= 1'b1;
			valid_q  <= 1'b0;
			step_cnt <= '0;
			seg      <= SEG_STEM;
			pos      <= 4'd0;
			pix_cnt  <= 5'd0;
		end
		else if (active)
		begin
			if (valid_q)
			begin
				if (grant)
				begin
					valid_q  <= 1'b0;
					step_cnt <= '0;	// divider restarts next cycle
					pix_cnt  <= pix_cnt + 5'd1;
					if (pix_cnt == GLYPH_PIXELS - 5'd1)
						active <= 1'b0;
					case (seg)
						SEG_STEM:
						begin
							if (pos == STEM_LEN - 4'd1)
							begin
								seg <= SEG_A;
								pos <= 4'd1;	// wings skip the origin
							end
							else
								pos <= pos + 4'd1;
						end
						SEG_A:
						begin
							if (pos == WING_LEN)
							begin
								seg <= SEG_B;
								pos <= 4'd1;
							end
							else
								pos <= pos + 4'd1;
						end
						default: pos <= pos + 4'd1;
					endcase
				end
			end
			else if (step_cnt == CNT_W'(STEP_CYCLES - 1))
				valid_q <= 1'b1;
			else
				step_cnt <= step_cnt + 1'b1;
		end
	end

	// axis directions of the current segment
	always_comb
	begin
		x_inc = 1'b0;
		x_dec = 1'b0;
		y_inc = 1'b0;
		y_dec = 1'b0;
		case (dir_q)
			UP:
			begin
				y_inc = 1'b1;
				x_inc = (seg == SEG_A);
				x_dec = (seg == SEG_B);
			end
			DOWN:
			begin
				y_dec = 1'b1;
				x_inc = (seg == SEG_A);
				x_dec = (seg == SEG_B);
			end
			RIGHT:
			begin
				x_dec = 1'b1;
				y_dec = (seg == SEG_A);
				y_inc = (seg == SEG_B);
			end
			default:	// LEFT
			begin
				x_inc = 1'b1;
				y_dec = (seg == SEG_A);
				y_inc = (seg == SEG_B);
			end
		endcase
	end

	assign off_x = coord_x_t'(pos);
	assign off_y = coord_y_t'(pos);

	always_comb
	begin
		req.valid  = valid_q;
		req.x      = x_inc ? ORIGIN_X + off_x : (x_dec ? ORIGIN_X - off_x : ORIGIN_X);
		req.y      = y_inc ? ORIGIN_Y + off_y : (y_dec ? ORIGIN_Y - off_y : ORIGIN_Y);
		req.colour = ERASE ? COLOUR_ERASE : dir_colour(dir_q);
	end

	assign busy = active;

	// back-pressure must not change the pixel on offer
	a_req_hold: assert property (@(posedge clk) disable iff (!reset_n)
		req.valid && !grant |=> $stable(req));

	// sequencer waits for idle before a restart
	a_no_restart: assert property (@(posedge clk) disable iff (!reset_n)
		start |-> !busy);

endmodule

/* logic/pixel_arbiter.sv */
// round-robin pixel bus arbiter
module pixel_arbiter
	import glyph_pkg::*;
(
	input  logic         clk,
	input  logic         reset_n,
	input  pixel_write_t req_draw,
	input  pixel_write_t req_erase,
	output logic         grant_draw,
	output logic         grant_erase,
	output pixel_write_t pixel
);

	logic last_erase;	// erase side won the last contest

	always_comb
	begin
		if (req_draw.valid && req_erase.valid)
		begin
			grant_draw  = last_erase;
			grant_erase = !last_erase;
		end
		else
		begin
			grant_draw  = req_draw.valid;
			grant_erase = req_erase.valid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!reset_n)
			last_erase <= 1'b0;
		else if (grant_draw || grant_erase)
			last_erase <= grant_erase;
	end

	// winner shows up on the bus one cycle later
	always_ff @(posedge clk)
	begin
		if (!reset_n)
			pixel.valid <= 1'b0;
		else if (grant_erase)
			pixel <= req_erase;
		else if (grant_draw)
			pixel <= req_draw;
		else
			pixel.valid <= 1'b0;
	end

	a_one_grant: assert property (@(posedge clk) disable iff (!reset_n)
		!(grant_draw && grant_erase));

endmodule

/* logic/glyph_sequencer.sv */
// request sequencer
module glyph_sequencer
	import glyph_pkg::*;
(
	input  logic       clk,
	input  logic       reset_n,
	input  logic       next_glyph,
	input  logic       clear_screen,
	input  direction_t dir,
	input  logic       draw_busy,
	input  logic       erase_busy,
	output logic       advance,
	output logic       draw_start,
	output logic       erase_start,
	output direction_t draw_dir,
	output direction_t erase_dir,
	output logic       busy
);

	typedef enum logic {IDLE, RUN} state_t;

	state_t     state;
	logic       has_prev;
	direction_t prev_dir;
	logic       take_next, take_clear;

	// clear wins when both pulses land together
	assign take_clear = (state == IDLE) && clear_screen && has_prev;
	assign take_next  = (state == IDLE) && next_glyph && !clear_screen;

	assign advance     = take_next;
	assign draw_start  = take_next;
	assign erase_start = (take_next && has_prev) || take_clear;
	assign draw_dir    = dir;
	assign erase_dir   = prev_dir;
	assign busy        = (state == RUN);

	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			state    <= IDLE;
			has_prev <= 1'b0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (take_next)
					begin
						state    <= RUN;
						has_prev <= 1'b1;
						prev_dir <= dir;	// erased by the next request
					end
					else if (take_clear)
					begin
						state    <= RUN;
						has_prev <= 1'b0;
					end
				end
				default:
				begin
					if (!draw_busy && !erase_busy)
						state <= IDLE;
				end
			endcase
		end
	end

endmodule

/* logic/glyph_display.sv */
// glyph display top level
module glyph_display
	import glyph_pkg::*;
#(
	parameter int STEP_CYCLES = 4
) (
	input  logic         clk,
	input  logic         reset_n,
	input  logic         next_glyph,
	input  logic         clear_screen,
	output pixel_write_t pixel,
	output logic         busy
);

	direction_t   pick_dir, draw_dir, erase_dir;
	logic         advance;
	logic         draw_start, erase_start;
	logic         draw_busy, erase_busy;
	logic         grant_draw, grant_erase;
	pixel_write_t req_draw, req_erase;

	glyph_picker picker (
		.clk     (clk),
		.reset_n (reset_n),
		.advance (advance),
		.dir     (pick_dir)
	);

	glyph_sequencer sequencer (
		.clk          (clk),
		.reset_n      (reset_n),
		.next_glyph   (next_glyph),
		.clear_screen (clear_screen),
		.dir          (pick_dir),
		.draw_busy    (draw_busy),
		.erase_busy   (erase_busy),
		.advance      (advance),
		.draw_start   (draw_start),
		.erase_start  (erase_start),
		.draw_dir     (draw_dir),
		.erase_dir    (erase_dir),
		.busy         (busy)
	);

	glyph_tracer #(.STEP_CYCLES(STEP_CYCLES), .ERASE(1'b0)) draw_tracer (
		.clk     (clk),
		.reset_n (reset_n),
		.start   (draw_start),
		.dir     (draw_dir),
		.grant   (grant_draw),
		.req     (req_draw),
		.busy    (draw_busy)
	);

	// same tracer, black pixels over the previous arrow
	glyph_tracer #(.STEP_CYCLES(STEP_CYCLES), .ERASE(1'b1)) erase_tracer (
		.clk     (clk),
		.reset_n (reset_n),
		.start   (erase_start),
		.dir     (erase_dir),
		.grant   (grant_erase),
		.req     (req_erase),
		.busy    (erase_busy)
	);

	pixel_arbiter arbiter (
		.clk         (clk),
		.reset_n     (reset_n),
		.req_draw    (req_draw),
		.req_erase   (req_erase),
		.grant_draw  (grant_draw),
		.grant_erase (grant_erase),
		.pixel       (pixel)
	);

endmodule

/* testbench/glyph_tb.sv */
// glyph display testbench
module glyph_tb
	import glyph_pkg::*;
();

	localparam int STEP_CYCLES = 4;

	logic         clk;
	logic         reset_n;
	logic         next_glyph;
	logic         clear_screen;
	pixel_write_t pixel;
	logic         busy;

	pixel_write_t draw_q[$];	// expected coloured pixels, in order
	pixel_write_t erase_q[$];	// expected black pixels, in order
	logic [7:0]   cmd_q[$];
	direction_t   dir_q[$];

	logic [3:0]   lfsr_m;
	logic         has_prev_m;
	direction_t   prev_dir_m;
	logic         monitor_on;
	pixel_write_t want;
	int           cycles = 0;
	int           cycle_limit;

	glyph_display #(.STEP_CYCLES(STEP_CYCLES)) dut (
		.clk          (clk),
		.reset_n      (reset_n),
		.next_glyph   (next_glyph),
		.clear_screen (clear_screen),
		.pixel        (pixel),
		.busy         (busy)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic void abort_run(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1);
	endfunction

	task automatic check_pixel(input string name, input pixel_write_t got, input pixel_write_t exp);
		if (got !== exp)
			abort_run($sformatf("CHECK FAILED: %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_dir(input string name, input direction_t got, input direction_t exp);
		if (got !== exp)
			abort_run($sformatf("CHECK FAILED: %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_busy(input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("CHECK FAILED: busy got %h expected %h", got, exp));
	endtask

	// reference lfsr, shifts toward bit 3
	function automatic logic [3:0] lfsr_next(input logic [3:0] s);
		return {s[2:0], s[2] ^ s[3]};
	endfunction

	function automatic direction_t lfsr_dir(input logic [3:0] s);
		direction_t d;
		if (s < 4'd4)
			d = UP;
		else if (s < 4'd8)
			d = DOWN;
		else if (s < 4'd12)
			d = LEFT;
		else
			d = RIGHT;
		return d;
	endfunction

	function automatic colour_t expected_colour(input direction_t d);
		colour_t c;
		case (d)
			UP:      c = 3'b111;
			DOWN:    c = 3'b001;
			RIGHT:   c = 3'b011;
			default: c = 3'b010;
		endcase
		return c;
	endfunction

	// pixel k of an arrow: stem, then wing A, then wing B
	function automatic pixel_write_t arrow_pixel(input direction_t d, input int k, input bit erase);
		int sx, sy, px, py, vx, vy, m;
		pixel_write_t p;
		sx = 0;
		sy = 0;
		px = 0;
		py = 0;
		case (d)
			UP:      sy = 1;
			DOWN:    sy = -1;
			RIGHT:   sx = -1;
			default: sx = 1;
		endcase
		if (sx == 0)
			px = 1;	// vertical stem, wings spread in x
		else
			py = -1;
		if (k < int'(STEM_LEN))
		begin
			m = k;
			vx = sx;
			vy = sy;
		end
		else if (k < int'(STEM_LEN) + int'(WING_LEN))
		begin
			m = k - int'(STEM_LEN) + 1;
			vx = sx + px;
			vy = sy + py;
		end
		else
		begin
			m = k - int'(STEM_LEN) - int'(WING_LEN) + 1;
			vx = sx - px;
			vy = sy - py;
		end
		p.valid  = 1'b1;
		p.x      = coord_x_t'(int'(ORIGIN_X) + m * vx);
		p.y      = coord_y_t'(int'(ORIGIN_Y) + m * vy);
		p.colour = erase ? COLOUR_ERASE : expected_colour(d);
		return p;
	endfunction

	task automatic queue_arrow(input direction_t d, input bit erase);
		for (int k = 0; k < int'(GLYPH_PIXELS); k++)
		begin
			if (erase)
				erase_q.push_back(arrow_pixel(d, k, 1'b1));
			else
				draw_q.push_back(arrow_pixel(d, k, 1'b0));
		end
	endtask

	function automatic direction_t name_to_dir(input logic [39:0] word);
		direction_t d;
		d = UP;
		case (word)
			40'("UP"):    d = UP;
			40'("DOWN"):  d = DOWN;
			40'("LEFT"):  d = LEFT;
			40'("RIGHT"): d = RIGHT;
			default:      abort_run("unknown direction name in the trace file");
		endcase
		return d;
	endfunction

	task automatic read_trace;
		int fd;
		int n;
		logic [39:0]  word;
		logic [799:0] rest;
		fd = $fopen("testbench/glyph_trace.txt", "r");
		if (fd == 0)
			abort_run("cannot open testbench/glyph_trace.txt");
		while (!$feof(fd))
		begin
			n = $fscanf(fd, "%s", word);
			if (n == 1)
			begin
				if (word == 40'("#"))
					n = $fgets(rest, fd);	// comment line
				else if (word == 40'("N"))
				begin
					n = $fscanf(fd, "%s", word);
					cmd_q.push_back("N");
					dir_q.push_back(name_to_dir(word));
				end
				else if (word == 40'("C") || word == 40'("X"))
				begin
					cmd_q.push_back(word[7:0]);
					dir_q.push_back(UP);	// unused
				end
				else
					abort_run("unknown command in the trace file");
			end
		end
		$fclose(fd);
	endtask

	task automatic wait_idle;
		while (busy !== 1'b0)
		begin
			@(posedge clk);
			#1;
		end
		if (draw_q.size() != 0 || erase_q.size() != 0)
			abort_run($sformatf("busy fell with %0d draw and %0d erase pixels still missing",
				draw_q.size(), erase_q.size()));
	endtask

	task automatic run_next(input direction_t trace_dir);
		direction_t d;
		d = lfsr_dir(lfsr_m);
		check_dir("lfsr model", d, trace_dir);
		check_dir("pick_dir", dut.pick_dir, trace_dir);
		queue_arrow(d, 1'b0);
		if (has_prev_m)
			queue_arrow(prev_dir_m, 1'b1);	// old arrow goes black
		prev_dir_m = d;
		has_prev_m = 1'b1;
		lfsr_m = lfsr_next(lfsr_m);
		next_glyph = 1'b1;
		@(posedge clk);
		#1;
		next_glyph = 1'b0;
		check_busy(busy, 1'b1);
	endtask

	task automatic run_clear;
		logic expect_busy;
		expect_busy = has_prev_m;	// nothing to erase means no run
		if (has_prev_m)
			queue_arrow(prev_dir_m, 1'b1);
		has_prev_m = 1'b0;
		clear_screen = 1'b1;
		@(posedge clk);
		#1;
		clear_screen = 1'b0;
		check_busy(busy, expect_busy);
	endtask

	task automatic run_ignored;
		if (busy !== 1'b1)
			abort_run("an ignored next_glyph was due but the DUT was already idle");
		next_glyph = 1'b1;
		@(posedge clk);
		#1;
		next_glyph = 1'b0;
		check_busy(busy, 1'b1);
	endtask

	// pixel bus monitor, sorted by colour
	always @(negedge clk)
	begin
		if (monitor_on)
		begin
			if (pixel.valid === 1'b1)
			begin
				if (pixel.colour == COLOUR_ERASE)
				begin
					if (erase_q.size() == 0)
						abort_run("a black pixel appeared with no erase expected");
					want = erase_q.pop_front();
					check_pixel("erase pixel", pixel, want);
				end
				else
				begin
					if (draw_q.size() == 0)
						abort_run("a coloured pixel appeared with no draw expected");
					want = draw_q.pop_front();
					check_pixel("draw pixel", pixel, want);
				end
			end
			else if (pixel.valid !== 1'b0)
				abort_run("pixel valid is unknown");
		end
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycle_limit != 0 && cycles >= cycle_limit)
			abort_run($sformatf("timeout, the run took more than %0d cycles", cycle_limit));
	end

	initial
	begin
		reset_n      = 1'b0;
		next_glyph   = 1'b0;
		clear_screen = 1'b0;
		monitor_on   = 1'b0;
		cycle_limit  = 0;
		lfsr_m       = 4'b1110;
		has_prev_m   = 1'b0;
		prev_dir_m   = UP;
		read_trace();
		cycle_limit = cmd_q.size() * 2 * int'(GLYPH_PIXELS) * (STEP_CYCLES + 2) + 100;
		repeat (3) @(posedge clk);
		#1;
		reset_n = 1'b1;
		monitor_on = 1'b1;
		repeat (6)	// idle after reset, monitor flags any pixel
		begin
			@(posedge clk);
			#1;
			check_busy(busy, 1'b0);
		end
		foreach (cmd_q[i])
		begin
			case (cmd_q[i])
				"N":
				begin
					wait_idle();
					run_next(dir_q[i]);
				end
				"C":
				begin
					wait_idle();
					run_clear();
				end
				default: run_ignored();
			endcase
		end
		wait_idle();
		repeat (4) @(posedge clk);
		$display("Done: no errors");
		$finish;
	end

endmodule

/* testbench/glyph_trace.txt */
# command per line: N <direction> draws the next arrow, C clears the current one
# X pulses next_glyph while busy and must be ignored
N RIGHT
N RIGHT
X
N LEFT
N UP
C
C
N UP
X
N DOWN
N LEFT
N UP
C
N DOWN
N RIGHT
X
N LEFT
N DOWN
C
C
N LEFT
N DOWN

/* src.f */
logic/glyph_pkg.sv
logic/glyph_picker.sv
logic/glyph_tracer.sv
logic/pixel_arbiter.sv
logic/glyph_sequencer.sv
logic/glyph_display.sv
testbench/glyph_tb.sv

/* run.sh */
#!/bin/sh
# build and run the glyph display testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module glyph_tb -f src.f -o glyph_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/glyph_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit 1
fi

exit 0
